/* common/icache_pkg.sv */
// ----------------------------------------------------------
// Widths and pipeline structs shared by the cache stages
// Index and tag fields are sized for any LINE_COUNT
// The way field covers at most four ways
// ----------------------------------------------------------
`default_nettype none

package icache_pkg;

    localparam int unsigned ADDR_W    = 16;
    localparam int unsigned ID_W      = 4;
    localparam int unsigned LINE_W    = 64;
    localparam int unsigned APB_W     = 32;
    localparam int unsigned BEATS     = LINE_W / APB_W;
    localparam int unsigned OFFSET_W  = $clog2(LINE_W / 8);
    // Line address without byte offset
    localparam int unsigned LADDR_W   = ADDR_W - OFFSET_W;
    localparam int unsigned WAY_SEL_W = 2;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
    } fetch_req_t;

    typedef struct packed {
        fetch_req_t             req;
        logic [WAY_SEL_W-1:0]   way;
        logic                   hit;
        logic                   error;
    } tag_out_t;

    typedef struct packed {
        tag_out_t          tag;
        logic [LINE_W-1:0] data;
    } lookup_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic              hit;
        logic              error;
        logic [LINE_W-1:0] data;
    } fetch_rsp_t;

    typedef struct packed {
        logic [LADDR_W-1:0]   index;
        logic [WAY_SEL_W-1:0] way;
        logic [LADDR_W-1:0]   tag;
        logic                 error;
        logic [LINE_W-1:0]    data;
    } refill_t;

endpackage

`default_nettype wire

/* logic/icache_sram.sv */
// ----------------------------------------------------------
// Single-port register array, read data one cycle after req
// Read data holds its value across writes and idle cycles
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_sram #(
    parameter int unsigned DEPTH = 8,
    parameter int unsigned WIDTH = 32
) (
    input  wire logic                     clk_i,
    input  wire logic                     req_i,
    input  wire logic                     we_i,
    input  wire logic [$clog2(DEPTH)-1:0] addr_i,
    input  wire logic [WIDTH-1:0]         wdata_i,
    output logic      [WIDTH-1:0]         rdata_o
);

    logic [WIDTH-1:0] mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* icache_lookup/icache_tag_stage.sv */
// ----------------------------------------------------------
// Tag lookup with init/flush clearing and refill writes
// Clearing beats refill writes, refill writes beat lookups
// A held item is looked up again after any tag write
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_tag_stage import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 8,
    parameter int unsigned WAY_COUNT  = 2
) (
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire logic       flush_valid_i,
    output logic            flush_ready_o,
    input  wire fetch_req_t req_i,
    input  wire logic       req_valid_i,
    output logic            req_ready_o,
    input  wire refill_t    refill_i,
    input  wire logic       refill_valid_i,
    output tag_out_t        tag_o,
    output logic            tag_valid_o,
    input  wire logic       tag_ready_i
);

    localparam int unsigned INDEX_W = $clog2(LINE_COUNT);
    localparam int unsigned TAG_W   = LADDR_W - INDEX_W;

    logic [INDEX_W:0]     init_cnt_q;
    logic                 init_phase;
    logic                 flush_pend_q;
    fetch_req_t           req_q;
    logic                 valid_q;
    logic                 rd_fresh_q;
    logic                 buf_valid_q;
    logic                 accept;
    logic                 reread;
    logic                 rd_lookup;
    logic                 wr_any;
    logic [INDEX_W-1:0]   tag_addr;
    logic [WAY_COUNT-1:0] tag_en;
    logic [TAG_W+1:0]     tag_wdata;
    logic [TAG_W+1:0]     tag_rdata [WAY_COUNT];
    logic [WAY_COUNT-1:0] line_hit;
    logic [WAY_COUNT-1:0] line_err;
    tag_out_t             cmp;
    tag_out_t             buf_q;

    // ------------------------------------------------------------
    // Init and flush counter
    // ------------------------------------------------------------
    assign init_phase    = init_cnt_q != (INDEX_W + 1)'(LINE_COUNT);
    assign flush_ready_o = flush_valid_i && flush_pend_q && !init_phase;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_cnt_q   <= '0;
            flush_pend_q <= 1'b0;
        end else if (init_phase) begin
            init_cnt_q <= init_cnt_q + 1'b1;
        end else if (flush_valid_i && !flush_pend_q) begin
            init_cnt_q   <= '0;
            flush_pend_q <= 1'b1;
        end else if (flush_ready_o) begin
            flush_pend_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Tag port arbitration
    // ------------------------------------------------------------
    assign wr_any      = init_phase || refill_valid_i;
    assign req_ready_o = !wr_any && (!valid_q || (tag_valid_o && tag_ready_i));
    assign accept      = req_valid_i && req_ready_o;
    // Held item whose last result was overwritten
    assign reread      = valid_q && !rd_fresh_q && !buf_valid_q && !wr_any;
    assign rd_lookup   = accept || reread;

    always_comb begin
        tag_addr  = accept ? req_i.addr[OFFSET_W +: INDEX_W] : req_q.addr[OFFSET_W +: INDEX_W];
        tag_en    = {WAY_COUNT{rd_lookup}};
        tag_wdata = {1'b1, refill_i.error, refill_i.tag[TAG_W-1:0]};
        if (init_phase) begin
            tag_addr  = init_cnt_q[INDEX_W-1:0];
            tag_en    = '1;
            tag_wdata = '0;
        end else if (refill_valid_i) begin
            tag_addr = refill_i.index[INDEX_W-1:0];
            for (int w = 0; w < WAY_COUNT; w++) begin
                tag_en[w] = refill_i.way == WAY_SEL_W'(w);
            end
        end
    end

    // Stored word is {valid, error, tag}
    for (genvar w = 0; w < WAY_COUNT; w++) begin : g_way
        icache_sram #(
            .DEPTH ( LINE_COUNT ),
            .WIDTH ( TAG_W + 2  )
        ) i_tag (
            .clk_i   ( clk_i        ),
            .req_i   ( tag_en[w]    ),
            .we_i    ( wr_any       ),
            .addr_i  ( tag_addr     ),
            .wdata_i ( tag_wdata    ),
            .rdata_o ( tag_rdata[w] )
        );
        assign line_hit[w] = tag_rdata[w][TAG_W+1]
                             && (tag_rdata[w][TAG_W-1:0] == req_q.addr[ADDR_W-1 -: TAG_W]);
        assign line_err[w] = line_hit[w] && tag_rdata[w][TAG_W];
    end

    // Lowest hitting way wins
    always_comb begin
        cmp       = '0;
        cmp.req   = req_q;
        cmp.hit   = |line_hit;
        cmp.error = |line_err;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            if (line_hit[w]) begin
                cmp.way = WAY_SEL_W'(w);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q     <= 1'b0;
            rd_fresh_q  <= 1'b0;
            buf_valid_q <= 1'b0;
        end else begin
            rd_fresh_q <= rd_lookup;
            if (accept) begin
                valid_q <= 1'b1;
            end else if (tag_valid_o && tag_ready_i) begin
                valid_q <= 1'b0;
            end
            if (accept || wr_any) begin
                buf_valid_q <= 1'b0;
            end else if (rd_fresh_q) begin
                buf_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (rd_fresh_q) begin
            buf_q <= cmp;
        end
    end

    // Fall-through result buffer
    assign tag_o       = rd_fresh_q ? cmp : buf_q;
    assign tag_valid_o = valid_q && (rd_fresh_q || buf_valid_q);

endmodule

`default_nettype wire

/* icache_lookup/icache_data_stage.sv */
// ----------------------------------------------------------
// Data bank read on hits and refill writes into the bank
// Refill writes stall the incoming handshake for that cycle
// WAY_COUNT and LINE_COUNT must be powers of two
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_data_stage import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 8,
    parameter int unsigned WAY_COUNT  = 2
) (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire tag_out_t tag_i,
    input  wire logic     tag_valid_i,
    output logic          tag_ready_o,
    input  wire refill_t  refill_i,
    input  wire logic     refill_valid_i,
    output lookup_t       look_o,
    output logic          look_valid_o,
    input  wire logic     look_ready_i
);

    localparam int unsigned INDEX_W = $clog2(LINE_COUNT);
    localparam int unsigned WAY_W   = $clog2(WAY_COUNT);
    localparam int unsigned DEPTH   = WAY_COUNT * LINE_COUNT;

    tag_out_t                 tag_q;
    logic                     look_valid_q;
    logic                     rd_fresh_q;
    logic                     handshake;
    logic                     rd_en;
    logic [$clog2(DEPTH)-1:0] data_addr;
    logic [LINE_W-1:0]        rdata;
    logic [LINE_W-1:0]        data_buf_q;

    assign tag_ready_o = !refill_valid_i && (!look_valid_q || look_ready_i);
    assign handshake   = tag_valid_i && tag_ready_o;
    // Misses never touch the data bank
    assign rd_en       = handshake && tag_i.hit;

    assign data_addr = refill_valid_i
        ? {refill_i.way[WAY_W-1:0], refill_i.index[INDEX_W-1:0]}
        : {tag_i.way[WAY_W-1:0], tag_i.req.addr[OFFSET_W +: INDEX_W]};

    icache_sram #(
        .DEPTH ( DEPTH  ),
        .WIDTH ( LINE_W )
    ) i_data (
        .clk_i   ( clk_i                   ),
        .req_i   ( refill_valid_i || rd_en ),
        .we_i    ( refill_valid_i          ),
        .addr_i  ( data_addr               ),
        .wdata_i ( refill_i.data           ),
        .rdata_o ( rdata                   )
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            look_valid_q <= 1'b0;
            rd_fresh_q   <= 1'b0;
        end else begin
            rd_fresh_q <= rd_en;
            if (handshake) begin
                look_valid_q <= 1'b1;
            end else if (look_ready_i) begin
                look_valid_q <= 1'b0;
            end
        end
    end

    // Keep read data while the miss stage is busy
    always_ff @(posedge clk_i) begin
        if (handshake) begin
            tag_q <= tag_i;
        end
        if (rd_fresh_q && !look_ready_i) begin
            data_buf_q <= rdata;
        end
    end

    assign look_o.tag   = tag_q;
    assign look_o.data  = rd_fresh_q ? rdata : data_buf_q;
    assign look_valid_o = look_valid_q;

endmodule

`default_nettype wire

/* logic/icache_miss_stage.sv */
// ----------------------------------------------------------
// Hits pass straight through; a miss blocks the pipeline
// while the line is read over APB in BEATS beats
// Victim way is one global round-robin pointer
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_miss_stage import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 8,
    parameter int unsigned WAY_COUNT  = 2
) (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire lookup_t           look_i,
    input  wire logic              look_valid_i,
    output logic                   look_ready_o,
    output fetch_rsp_t             rsp_o,
    output logic                   rsp_valid_o,
    input  wire logic              rsp_ready_i,
    output refill_t                refill_o,
    output logic                   refill_valid_o,
    output logic                   psel_o,
    output logic                   penable_o,
    output logic      [ADDR_W-1:0] paddr_o,
    input  wire logic [APB_W-1:0]  prdata_i,
    input  wire logic              pready_i,
    input  wire logic              pslverr_i
);

    localparam int unsigned INDEX_W = $clog2(LINE_COUNT);
    localparam int unsigned WAY_W   = $clog2(WAY_COUNT);
    localparam int unsigned BEAT_W  = $clog2(BEATS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SETUP,
        S_ACCESS,
        S_REFILL,
        S_RESP
    } state_e;

    state_e            state_q;
    logic [BEAT_W-1:0] beat_q;
    logic [WAY_W-1:0]  victim_q;
    logic              err_q;
    logic [LINE_W-1:0] line_q;
    logic [ADDR_W-1:0] addr;

    assign addr    = look_i.tag.req.addr;
    assign psel_o    = (state_q == S_SETUP) || (state_q == S_ACCESS);
    assign penable_o = state_q == S_ACCESS;
    assign paddr_o   = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}}
                       + ADDR_W'(beat_q) * ADDR_W'(APB_W / 8);

    always_comb begin
        rsp_o        = '{addr: addr, id: look_i.tag.req.id, hit: look_i.tag.hit,
                         error: look_i.tag.error, data: look_i.data};
        rsp_valid_o  = 1'b0;
        look_ready_o = 1'b0;
        if (state_q == S_IDLE && look_valid_i && look_i.tag.hit) begin
            rsp_valid_o  = 1'b1;
            look_ready_o = rsp_ready_i;
        end else if (state_q == S_RESP) begin
            rsp_o.hit    = 1'b0;
            rsp_o.error  = err_q;
            rsp_o.data   = line_q;
            rsp_valid_o  = 1'b1;
            look_ready_o = rsp_ready_i;
        end
    end

    assign refill_valid_o = state_q == S_REFILL;
    assign refill_o = '{index: LADDR_W'(addr[OFFSET_W +: INDEX_W]),
                        way:   WAY_SEL_W'(victim_q),
                        tag:   LADDR_W'(addr >> (OFFSET_W + INDEX_W)),
                        error: err_q,
                        data:  line_q};

    // ------------------------------------------------------------
    // Refill FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= S_IDLE;
            beat_q   <= '0;
            victim_q <= '0;
            err_q    <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (look_valid_i && !look_i.tag.hit) begin
                        state_q <= S_SETUP;
                        beat_q  <= '0;
                        err_q   <= 1'b0;
                    end
                end
                S_SETUP: state_q <= S_ACCESS;
                S_ACCESS: begin
                    if (pready_i) begin
                        // Any failing beat taints the whole line
                        err_q <= err_q | pslverr_i;
                        if (beat_q == BEAT_W'(BEATS - 1)) begin
                            state_q <= S_REFILL;
                        end else begin
                            beat_q  <= beat_q + 1'b1;
                            state_q <= S_SETUP;
                        end
                    end
                end
                S_REFILL: begin
                    state_q  <= S_RESP;
                    victim_q <= (victim_q == WAY_W'(WAY_COUNT - 1)) ? '0 : victim_q + 1'b1;
                end
                S_RESP: begin
                    if (rsp_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Beat k fills bits k*APB_W upward
    always_ff @(posedge clk_i) begin
        if (state_q == S_ACCESS && pready_i) begin
            line_q[beat_q*APB_W +: APB_W] <= prdata_i;
        end
    end

endmodule

`default_nettype wire

/* logic/icache_top.sv */
// ----------------------------------------------------------
// Instruction cache top, tag, data and miss stages in a row
// APB reads only, one refill outstanding at a time
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int unsigned LINE_COUNT = 8,
    parameter int unsigned WAY_COUNT  = 2
) (
    input  wire logic              clk_i,
    input  wire logic              rst_ni,
    input  wire logic              flush_valid_i,
    output logic                   flush_ready_o,
    input  wire fetch_req_t        req_i,
    input  wire logic              req_valid_i,
    output logic                   req_ready_o,
    output fetch_rsp_t             rsp_o,
    output logic                   rsp_valid_o,
    input  wire logic              rsp_ready_i,
    output logic                   psel_o,
    output logic                   penable_o,
    output logic      [ADDR_W-1:0] paddr_o,
    input  wire logic [APB_W-1:0]  prdata_i,
    input  wire logic              pready_i,
    input  wire logic              pslverr_i
);

    tag_out_t tag;
    logic     tag_valid;
    logic     tag_ready;
    lookup_t  look;
    logic     look_valid;
    logic     look_ready;
    refill_t  refill;
    logic     refill_valid;

    icache_tag_stage #(
        .LINE_COUNT ( LINE_COUNT ),
        .WAY_COUNT  ( WAY_COUNT  )
    ) i_tag_stage (
        .clk_i, .rst_ni, .flush_valid_i, .flush_ready_o, .req_i, .req_valid_i, .req_ready_o,
        .refill_i       ( refill       ),
        .refill_valid_i ( refill_valid ),
        .tag_o          ( tag          ),
        .tag_valid_o    ( tag_valid    ),
        .tag_ready_i    ( tag_ready    )
    );

    icache_data_stage #(
        .LINE_COUNT ( LINE_COUNT ),
        .WAY_COUNT  ( WAY_COUNT  )
    ) i_data_stage (
        .clk_i, .rst_ni,
        .tag_i          ( tag          ),
        .tag_valid_i    ( tag_valid    ),
        .tag_ready_o    ( tag_ready    ),
        .refill_i       ( refill       ),
        .refill_valid_i ( refill_valid ),
        .look_o         ( look         ),
        .look_valid_o   ( look_valid   ),
        .look_ready_i   ( look_ready   )
    );

    icache_miss_stage #(
        .LINE_COUNT ( LINE_COUNT ),
        .WAY_COUNT  ( WAY_COUNT  )
    ) i_miss_stage (
        .clk_i, .rst_ni, .rsp_o, .rsp_valid_o, .rsp_ready_i,
        .look_i         ( look         ),
        .look_valid_i   ( look_valid   ),
        .look_ready_o   ( look_ready   ),
        .refill_o       ( refill       ),
        .refill_valid_o ( refill_valid ),
        .psel_o, .penable_o, .paddr_o, .prdata_i, .pready_i, .pslverr_i
    );

endmodule

`default_nettype wire

/* testbench/icache_assert.sv */
// ----------------------------------------------------------
// Handshake and APB protocol checks, bound into icache_top
// All checks are idle while reset is asserted
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_assert import icache_pkg::*; (
    input wire logic              clk_i,
    input wire logic              rst_ni,
    input wire fetch_req_t        req_i,
    input wire logic              req_valid_i,
    input wire logic              req_ready_o,
    input wire fetch_rsp_t        rsp_o,
    input wire logic              rsp_valid_o,
    input wire logic              rsp_ready_i,
    input wire logic              psel_o,
    input wire logic              penable_o,
    input wire logic [ADDR_W-1:0] paddr_o,
    input wire logic              pready_i
);

    int unsigned fail_count = 0;

    // Valid and payload hold until the transfer
    req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i))
        else begin
            fail_count++;
            $error("request valid dropped or payload changed before ready");
        end

    rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else begin
            fail_count++;
            $error("response valid dropped or payload changed before ready");
        end

    // ------------------------------------------------------------
    // APB master side
    // ------------------------------------------------------------
    apb_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        penable_o && pready_i |=> !penable_o)
        else begin
            fail_count++;
            $error("penable still high after the transfer completed");
        end

    apb_setup: assert property (@(posedge clk_i) disable iff (!rst_ni)
        psel_o && !penable_o |=> psel_o && penable_o)
        else begin
            fail_count++;
            $error("setup cycle not followed by access cycle");
        end

    apb_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        psel_o && !(penable_o && pready_i) |=> psel_o && $stable(paddr_o))
        else begin
            fail_count++;
            $error("paddr changed during a transfer");
        end

endmodule

bind icache_top icache_assert i_assert (.*);

`default_nettype wire

/* testbench/icache_tb.sv */
// ----------------------------------------------------------
// Cache testbench driven from the vectors file
// Memory word is address XOR 32'h5a5a_0000
// Addresses with bit 15 set answer with a slave error
// Responses are checked in request order
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

    localparam int unsigned LINE_COUNT  = 8;
    localparam int unsigned WAY_COUNT   = 2;
    localparam int unsigned CLK_PERIOD  = 100;
    localparam int unsigned FIELDS      = 6;
    localparam int unsigned MAX_TESTS   = 32;
    localparam int unsigned WDOG_CYCLES = 40;
    localparam logic [63:0] OP_READ     = 64'h1;
    localparam logic [63:0] OP_FLUSH    = 64'hf;
    localparam logic [31:0] SEED        = 32'h273d_a721;

    logic              clk;
    logic              rst_n;
    logic              flush_valid;
    logic              flush_ready;
    fetch_req_t        req;
    logic              req_valid;
    logic              req_ready;
    fetch_rsp_t        rsp;
    logic              rsp_valid;
    logic              rsp_ready;
    logic              psel;
    logic              penable;
    logic [ADDR_W-1:0] paddr;
    logic [APB_W-1:0]  prdata;
    logic              pready;
    logic              pslverr;

    logic [63:0]       vec_mem [MAX_TESTS*FIELDS];
    int unsigned       num_tests;
    logic              loaded;
    int unsigned       tests_done;
    int unsigned       errors;
    fetch_rsp_t        exp_q [$];
    int unsigned       num_q [$];

    icache_top #(
        .LINE_COUNT ( LINE_COUNT ),
        .WAY_COUNT  ( WAY_COUNT  )
    ) i_dut (
        .clk_i         ( clk         ),
        .rst_ni        ( rst_n       ),
        .flush_valid_i ( flush_valid ),
        .flush_ready_o ( flush_ready ),
        .req_i         ( req         ),
        .req_valid_i   ( req_valid   ),
        .req_ready_o   ( req_ready   ),
        .rsp_o         ( rsp         ),
        .rsp_valid_o   ( rsp_valid   ),
        .rsp_ready_i   ( rsp_ready   ),
        .psel_o        ( psel        ),
        .penable_o     ( penable     ),
        .paddr_o       ( paddr       ),
        .prdata_i      ( prdata      ),
        .pready_i      ( pready      ),
        .pslverr_i     ( pslverr     )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_rsp(input string name, input fetch_rsp_t exp, input fetch_rsp_t act);
        tests_done++;
        if (act !== exp) begin
            errors++;
            $write("[FAIL] %s expected addr=%h id=%h hit=%b err=%b data=%h",
                   name, exp.addr, exp.id, exp.hit, exp.error, exp.data);
            $display(", actual addr=%h id=%h hit=%b err=%b data=%h",
                     act.addr, act.id, act.hit, act.error, act.data);
        end else begin
            $display("[ OK ] %s id=%h hit=%b err=%b data=%h",
                     name, act.id, act.hit, act.error, act.data);
        end
    endtask

    // Clearing all lines takes at least LINE_COUNT cycles
    task automatic check_flush(input string name, input int unsigned cycles);
        tests_done++;
        if (cycles <= LINE_COUNT) begin
            errors++;
            $display("[FAIL] %s expected more than %0d cycles, actual %0d cycles",
                     name, LINE_COUNT, cycles);
        end else begin
            $display("[ OK ] %s done after %0d cycles", name, cycles);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic send_req(input fetch_rsp_t exp, input int unsigned num);
        @(negedge clk);
        req.addr  = exp.addr;
        req.id    = exp.id;
        req_valid = 1'b1;
        do begin
            @(posedge clk);
        end while (!req_ready);
        exp_q.push_back(exp);
        num_q.push_back(num);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_flush(input int unsigned num);
        int unsigned cycles;
        cycles      = 0;
        flush_valid = 1'b1;
        do begin
            @(posedge clk);
            cycles++;
        end while (!flush_ready);
        @(negedge clk);
        flush_valid = 1'b0;
        check_flush($sformatf("test %0d flush", num), cycles);
    endtask

    // Requester ready and APB memory share one random stream
    initial begin : responder
        int unsigned apb_wait;
        rsp_ready = 1'b0;
        prdata    = '0;
        pready    = 1'b0;
        pslverr   = 1'b0;
        apb_wait  = 0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            rsp_ready = ($urandom % 4) != 0;
            pready    = 1'b0;
            pslverr   = 1'b0;
            if (psel && !penable) begin
                apb_wait = $urandom % 3;
            end else if (psel && penable) begin
                if (apb_wait == 0) begin
                    pready  = 1'b1;
                    prdata  = 32'(paddr) ^ 32'h5a5a_0000;
                    pslverr = paddr[15];
                end else begin
                    apb_wait--;
                end
            end
        end
    end

    initial begin : monitor
        fetch_rsp_t  exp;
        int unsigned num;
        forever begin
            @(posedge clk);
            if (rst_n && rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Response with id %h arrived with no request outstanding", rsp.id);
                end else begin
                    exp = exp_q.pop_front();
                    num = num_q.pop_front();
                    check_rsp($sformatf("test %0d read %h", num, exp.addr), exp, rsp);
                end
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (num_tests * WDOG_CYCLES) @(posedge clk);
        $display("Run did not finish within %0d cycles", num_tests * WDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    initial begin : stimulus
        logic [63:0] op;
        fetch_rsp_t  exp;
        rst_n       = 1'b0;
        flush_valid = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        loaded      = 1'b0;
        num_tests   = 0;
        tests_done  = 0;
        errors      = 0;
        $readmemh("testbench/icache_vectors.txt", vec_mem);
        while (num_tests < MAX_TESTS
               && (vec_mem[num_tests*FIELDS] == OP_READ
                   || vec_mem[num_tests*FIELDS] == OP_FLUSH)) begin
            num_tests++;
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int unsigned i = 0; i < num_tests; i++) begin
            op = vec_mem[i*FIELDS];
            if (op == OP_FLUSH) begin
                @(negedge clk);
                req_valid = 1'b0;
                wait_drained();
                run_flush(i + 1);
            end else begin
                exp.addr  = ADDR_W'(vec_mem[i*FIELDS+1]);
                exp.id    = ID_W'(vec_mem[i*FIELDS+2]);
                exp.hit   = vec_mem[i*FIELDS+3][0];
                exp.error = vec_mem[i*FIELDS+4][0];
                exp.data  = vec_mem[i*FIELDS+5];
                send_req(exp, i + 1);
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
        wait_drained();
        repeat (2) @(negedge clk);
        $display("%0d of %0d tests done, %0d check errors, %0d assertion failures",
                 tests_done, num_tests, errors, i_dut.i_assert.fail_count);
        if (errors == 0 && i_dut.i_assert.fail_count == 0
            && tests_done == num_tests && num_tests != 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* icache.f */
common/icache_pkg.sv
logic/icache_sram.sv
icache_lookup/icache_tag_stage.sv
icache_lookup/icache_data_stage.sv
logic/icache_miss_stage.sv
logic/icache_top.sv
testbench/icache_assert.sv
testbench/icache_tb.sv

/* testbench/icache_vectors.txt */
// op addr id hit err data, hex; op 1 is a fetch, op f a flush with unused fields
// data is the two line words {base+4, base}, each word XOR 32'h5a5a_0000
1 0040 1 0 0 5a5a00445a5a0040
1 0088 2 0 0 5a5a008c5a5a0088
1 0044 3 1 0 5a5a00445a5a0040
1 008c 4 1 0 5a5a008c5a5a0088
1 0010 5 0 0 5a5a00145a5a0010
1 0050 6 0 0 5a5a00545a5a0050
1 0090 7 0 0 5a5a00945a5a0090
1 0054 8 1 0 5a5a00545a5a0050
1 0010 9 0 0 5a5a00145a5a0010
1 0094 a 1 0 5a5a00945a5a0090
f 0000 0 0 0 0000000000000000
1 0040 b 0 0 5a5a00445a5a0040
1 8018 c 0 1 5a5a801c5a5a8018
1 801c d 1 1 5a5a801c5a5a8018
1 0044 e 1 0 5a5a00445a5a0040
1 8018 f 1 1 5a5a801c5a5a8018
1 0040 0 1 0 5a5a00445a5a0040
1 0088 1 0 0 5a5a008c5a5a0088
1 008c 2 1 0 5a5a008c5a5a0088
